// File: src/virtio_blk_pkg.sv
package virtio_blk_pkg;

   //////////////////////////////////////////////////////////////////////
   // legacy mmio register map
   localparam logic [11:0] REG_MAGIC         = 12'h000;
   localparam logic [11:0] REG_VERSION       = 12'h004;
   localparam logic [11:0] REG_DEVICE_ID     = 12'h008;
   localparam logic [11:0] REG_VENDOR_ID     = 12'h00c;
   localparam logic [11:0] REG_HOST_FEATURES = 12'h010;
   localparam logic [11:0] REG_QUEUE_NUM_MAX = 12'h034;
   localparam logic [11:0] REG_QUEUE_NUM     = 12'h038;
   localparam logic [11:0] REG_QUEUE_PFN     = 12'h040;
   localparam logic [11:0] REG_QUEUE_NOTIFY  = 12'h050;
   localparam logic [11:0] REG_INT_STATUS    = 12'h060;
   localparam logic [11:0] REG_INT_ACK       = 12'h064;
   localparam logic [11:0] REG_STATUS        = 12'h070;

   // identity
   localparam logic [31:0] MAGIC_VALUE    = 32'h7472_6976;
   localparam logic [31:0] VIRTIO_VERSION = 32'd1;
   localparam logic [31:0] DEVICE_ID_BLK  = 32'd2;
   localparam logic [31:0] VENDOR_ID      = 32'h554d_4551;
   localparam logic [31:0] QUEUE_NUM_MAX  = 32'd8;

   // ring geometry
   localparam logic [31:0] QUEUE_ALIGN   = 32'd4096;
   localparam logic [31:0] DESC_SIZE     = 32'd16;
   localparam logic [31:0] DESC_ADDR_OFS = 32'd4;
   localparam logic [31:0] DESC_LINK_OFS = 32'd12;

   localparam logic [31:0] BLK_T_IN     = 32'd0;
   localparam logic [31:0] BLK_T_OUT    = 32'd1;
   localparam logic [7:0]  BLK_S_OK     = 8'd0;
   localparam logic [7:0]  BLK_S_UNSUPP = 8'd2;

   localparam logic MEM_READ  = 1'b0;
   localparam logic MEM_WRITE = 1'b1;

   //////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [31:0] araddr;
      logic        arvalid;
      logic        rready;
      logic [31:0] awaddr;
      logic        awvalid;
      logic [31:0] wdata;
      logic        wvalid;
      logic        bready;
   } axil_req_t;

   typedef struct packed {
      logic        arready;
      logic [31:0] rdata;
      logic        rvalid;
      logic        awready;
      logic        wready;
      logic        bvalid;
      logic [1:0]  bresp;
   } axil_rsp_t;

   typedef struct packed {
      logic        enable;
      logic        mode;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
   } mem_req_t;

   typedef struct packed {
      logic        enable;
      logic [31:0] data;
   } mem_rsp_t;

   typedef struct packed {
      logic [15:0] queue_num;
      logic [19:0] queue_pfn;
   } ring_cfg_t;

   typedef struct packed {
      logic [15:0] head_idx;
      logic [31:0] btype;
      logic [31:0] status_addr;
   } chain_info_t;

   //////////////////////////////////////////////////////////////////////
   // ring layout
   function automatic logic [15:0] vq_slot(ring_cfg_t cfg, logic [15:0] idx);
      if (cfg.queue_num == 16'h0) begin
         return idx;
      end
      return idx % cfg.queue_num;
   endfunction

   function automatic logic [31:0] vq_desc_base(ring_cfg_t cfg);
      return {cfg.queue_pfn, 12'h000};
   endfunction

   function automatic logic [31:0] vq_avail_base(ring_cfg_t cfg);
      return vq_desc_base(cfg) + DESC_SIZE * {16'h0, cfg.queue_num};
   endfunction

   // used ring begins on the next page boundary after the avail ring
   function automatic logic [31:0] vq_used_base(ring_cfg_t cfg);
      logic [31:0] avail_end;
      avail_end = vq_avail_base(cfg) + 32'd4 + ({16'h0, cfg.queue_num} << 2);
      return (avail_end + QUEUE_ALIGN - 32'd1) & ~(QUEUE_ALIGN - 32'd1);
   endfunction

   function automatic logic [31:0] vq_desc_addr(ring_cfg_t cfg, logic [15:0] idx);
      return vq_desc_base(cfg) + DESC_SIZE * {16'h0, vq_slot(cfg, idx)};
   endfunction

endpackage

// File: src/virtio_mmio_regs.sv
`timescale 1ns/1ps

module virtio_mmio_regs (
   input  logic                      clk,
   input  logic                      rstn,
   input  virtio_blk_pkg::axil_req_t core_req,
   output virtio_blk_pkg::axil_rsp_t core_rsp,
   output virtio_blk_pkg::ring_cfg_t ring_cfg,
   output logic                      notify,
   input  logic                      irq_raise,
   output logic                      virtio_interrupt
);
   import virtio_blk_pkg::*;

   typedef enum logic [1:0] {
      ST_QUERY,
      ST_RREADY,
      ST_BREADY
   } bus_state_t;

   bus_state_t  bus_state;
   logic        arready;
   logic        rvalid;
   logic [31:0] rdata;
   logic        awready;
   logic        wready;
   logic        bvalid;
   logic [11:0] wr_ofs;
   logic [31:0] wr_data;
   logic [31:0] dev_status;
   logic        int_status;

   function automatic logic [31:0] read_reg(logic [11:0] ofs);
      case (ofs)
         REG_MAGIC:         return MAGIC_VALUE;
         REG_VERSION:       return VIRTIO_VERSION;
         REG_DEVICE_ID:     return DEVICE_ID_BLK;
         REG_VENDOR_ID:     return VENDOR_ID;
         REG_HOST_FEATURES: return 32'h0;
         REG_QUEUE_NUM_MAX: return QUEUE_NUM_MAX;
         REG_QUEUE_NUM:     return {16'h0, ring_cfg.queue_num};
         REG_QUEUE_PFN:     return {12'h0, ring_cfg.queue_pfn};
         REG_INT_STATUS:    return {31'h0, int_status};
         REG_STATUS:        return dev_status;
         default:           return 32'h0;
      endcase
   endfunction

   always_ff @(posedge clk) begin
      if (rstn) begin
         bus_state  <= ST_QUERY;
         arready    <= 1'b1;
         rvalid     <= 1'b0;
         awready    <= 1'b1;
         wready     <= 1'b1;
         bvalid     <= 1'b0;
         notify     <= 1'b0;
         ring_cfg   <= '0;
         dev_status <= 32'h0;
         int_status <= 1'b0;
      end else begin
         notify <= 1'b0;
         // address and data halves may come in either order
         if (core_req.awvalid && awready) begin
            wr_ofs  <= core_req.awaddr[11:0];
            awready <= 1'b0;
         end
         if (core_req.wvalid && wready) begin
            wr_data <= core_req.wdata;
            wready  <= 1'b0;
         end
         case (bus_state)
            ST_QUERY: begin
               if (core_req.arvalid && arready) begin
                  arready   <= 1'b0;
                  rvalid    <= 1'b1;
                  rdata     <= read_reg(core_req.araddr[11:0]);
                  bus_state <= ST_RREADY;
               end else if (!awready && !wready) begin
                  case (wr_ofs)
                     REG_QUEUE_NUM:    ring_cfg.queue_num <= wr_data[15:0];
                     REG_QUEUE_PFN:    ring_cfg.queue_pfn <= wr_data[19:0];
                     REG_QUEUE_NOTIFY: notify <= 1'b1;
                     REG_INT_ACK: begin
                        if (wr_data[0]) begin
                           int_status <= 1'b0;
                        end
                     end
                     REG_STATUS:       dev_status <= wr_data;
                     default: ;
                  endcase
                  arready   <= 1'b0;
                  bvalid    <= 1'b1;
                  bus_state <= ST_BREADY;
               end
            end
            ST_RREADY: begin
               if (core_req.rready) begin
                  rvalid    <= 1'b0;
                  arready   <= 1'b1;
                  bus_state <= ST_QUERY;
               end
            end
            default: begin
               if (core_req.bready) begin
                  bvalid    <= 1'b0;
                  arready   <= 1'b1;
                  awready   <= 1'b1;
                  wready    <= 1'b1;
                  bus_state <= ST_QUERY;
               end
            end
         endcase
         // a new batch end wins over a same-cycle ack
         if (irq_raise) begin
            int_status <= 1'b1;
         end
      end
   end

   assign core_rsp = '{arready: arready, rdata: rdata, rvalid: rvalid, awready: awready,
                       wready: wready, bvalid: bvalid, bresp: 2'b00};
   assign virtio_interrupt = int_status;

endmodule

// File: src/virtq_ctrl.sv
`timescale 1ns/1ps

module virtq_ctrl (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      notify,
   input  virtio_blk_pkg::ring_cfg_t ring_cfg,
   output virtio_blk_pkg::mem_req_t  mem_req,
   input  virtio_blk_pkg::mem_rsp_t  mem_rsp,
   output logic                      loader_start,
   output logic [15:0]               head_idx,
   input  virtio_blk_pkg::mem_req_t  loader_req,
   input  logic                      loader_done,
   output logic                      writer_start,
   output logic [15:0]               used_idx,
   input  virtio_blk_pkg::mem_req_t  writer_req,
   input  logic                      writer_done,
   output logic                      irq_raise
);
   import virtio_blk_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_AVAIL_IDX,
      S_AVAIL_ENT,
      S_LOAD_CHAIN,
      S_COMPLETE,
      S_RAISE_IRQ
   } ctrl_state_t;

   ctrl_state_t state;
   logic        own_en;
   logic [31:0] own_addr;
   logic [31:0] avail_base;
   mem_req_t    own_req;

   assign avail_base = vq_avail_base(ring_cfg);
   assign own_req = '{enable: own_en, mode: MEM_READ, addr: own_addr, wdata: 32'h0, wstrb: 4'h0};

   // memory port goes to whichever block is active
   always_comb begin
      case (state)
         S_LOAD_CHAIN: mem_req = loader_req;
         S_COMPLETE:   mem_req = writer_req;
         default:      mem_req = own_req;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         state        <= S_IDLE;
         own_en       <= 1'b0;
         loader_start <= 1'b0;
         writer_start <= 1'b0;
         irq_raise    <= 1'b0;
         used_idx     <= 16'h0;
      end else begin
         own_en       <= 1'b0;
         loader_start <= 1'b0;
         writer_start <= 1'b0;
         irq_raise    <= 1'b0;
         case (state)
            S_IDLE: begin
               if (notify) begin
                  own_en   <= 1'b1;
                  own_addr <= avail_base;
                  state    <= S_AVAIL_IDX;
               end
            end
            // avail idx lives in the low half of the first avail word
            S_AVAIL_IDX: begin
               if (mem_rsp.enable) begin
                  if (mem_rsp.data[15:0] != used_idx) begin
                     own_en   <= 1'b1;
                     own_addr <= avail_base + 32'd4 +
                                 ({16'h0, vq_slot(ring_cfg, used_idx)} << 2);
                     state    <= S_AVAIL_ENT;
                  end else begin
                     state <= S_RAISE_IRQ;
                  end
               end
            end
            S_AVAIL_ENT: begin
               if (mem_rsp.enable) begin
                  head_idx     <= mem_rsp.data[15:0];
                  used_idx     <= used_idx + 16'd1;
                  loader_start <= 1'b1;
                  state        <= S_LOAD_CHAIN;
               end
            end
            S_LOAD_CHAIN: begin
               if (loader_done) begin
                  writer_start <= 1'b1;
                  state        <= S_COMPLETE;
               end
            end
            S_COMPLETE: begin
               // recheck avail idx, more may have been posted
               if (writer_done) begin
                  own_en   <= 1'b1;
                  own_addr <= avail_base;
                  state    <= S_AVAIL_IDX;
               end
            end
            S_RAISE_IRQ: begin
               irq_raise <= 1'b1;
               state     <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

// File: src/desc_loader.sv
`timescale 1ns/1ps

module desc_loader (
   input  logic                        clk,
   input  logic                        rstn,
   input  logic                        loader_start,
   input  logic [15:0]                 head_idx,
   input  virtio_blk_pkg::ring_cfg_t   ring_cfg,
   output virtio_blk_pkg::mem_req_t    loader_req,
   input  virtio_blk_pkg::mem_rsp_t    mem_rsp,
   output logic                        loader_done,
   output virtio_blk_pkg::chain_info_t chain
);
   import virtio_blk_pkg::*;

   logic        busy;
   logic [2:0]  step;
   logic        req_en;
   logic [15:0] next_idx;
   logic [31:0] buf_addr;
   logic [31:0] rd_addr;

   // head addr, head link, out header type, 2nd link, 3rd addr, 3rd link
   always_comb begin
      case (step)
         3'd0:    rd_addr = vq_desc_addr(ring_cfg, chain.head_idx) + DESC_ADDR_OFS;
         3'd1:    rd_addr = vq_desc_addr(ring_cfg, chain.head_idx) + DESC_LINK_OFS;
         3'd2:    rd_addr = buf_addr;
         3'd4:    rd_addr = vq_desc_addr(ring_cfg, next_idx) + DESC_ADDR_OFS;
         default: rd_addr = vq_desc_addr(ring_cfg, next_idx) + DESC_LINK_OFS;
      endcase
   end

   assign loader_req = '{enable: req_en, mode: MEM_READ, addr: rd_addr,
                         wdata: 32'h0, wstrb: 4'h0};

   always_ff @(posedge clk) begin
      if (rstn) begin
         busy        <= 1'b0;
         step        <= 3'd0;
         req_en      <= 1'b0;
         loader_done <= 1'b0;
      end else begin
         req_en      <= 1'b0;
         loader_done <= 1'b0;
         if (loader_start) begin
            busy           <= 1'b1;
            step           <= 3'd0;
            req_en         <= 1'b1;
            chain.head_idx <= head_idx;
         end else if (busy && mem_rsp.enable) begin
            // next index sits in the low half of a link word
            case (step)
               3'd0:    buf_addr          <= mem_rsp.data;
               3'd1:    next_idx          <= mem_rsp.data[15:0];
               3'd2:    chain.btype       <= mem_rsp.data;
               3'd3:    next_idx          <= mem_rsp.data[15:0];
               3'd4:    chain.status_addr <= mem_rsp.data;
               default: ;
            endcase
            if (step == 3'd5) begin
               busy        <= 1'b0;
               loader_done <= 1'b1;
            end else begin
               step   <= step + 3'd1;
               req_en <= 1'b1;
            end
         end
      end
   end

endmodule

// File: src/completion_writer.sv
`timescale 1ns/1ps

module completion_writer (
   input  logic                        clk,
   input  logic                        rstn,
   input  logic                        writer_start,
   input  virtio_blk_pkg::chain_info_t chain,
   input  logic [15:0]                 used_idx,
   input  virtio_blk_pkg::ring_cfg_t   ring_cfg,
   output virtio_blk_pkg::mem_req_t    writer_req,
   input  virtio_blk_pkg::mem_rsp_t    mem_rsp,
   output logic                        writer_done
);
   import virtio_blk_pkg::*;

   logic        busy;
   logic [1:0]  step;
   logic        req_en;
   logic [15:0] slot;
   logic [31:0] entry_addr;
   logic [7:0]  status;

   // used_idx was already bumped for this request
   assign slot       = vq_slot(ring_cfg, used_idx - 16'd1);
   assign entry_addr = vq_used_base(ring_cfg) + 32'd4 + ({16'h0, slot} << 3);
   assign status     = (chain.btype == BLK_T_IN || chain.btype == BLK_T_OUT) ?
                       BLK_S_OK : BLK_S_UNSUPP;

   always_comb begin
      writer_req.enable = req_en;
      writer_req.mode   = MEM_WRITE;
      writer_req.wstrb  = 4'b1111;
      case (step)
         2'd0: begin
            writer_req.addr  = chain.status_addr;
            writer_req.wdata = {24'h0, status};
            writer_req.wstrb = 4'b0001;
         end
         2'd1: begin
            writer_req.addr  = entry_addr;
            writer_req.wdata = {16'h0, chain.head_idx};
         end
         // length word, no data moved
         2'd2: begin
            writer_req.addr  = entry_addr + 32'd4;
            writer_req.wdata = 32'h0;
         end
         default: begin
            writer_req.addr  = vq_used_base(ring_cfg);
            writer_req.wdata = {16'h0, used_idx};
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         busy        <= 1'b0;
         step        <= 2'd0;
         req_en      <= 1'b0;
         writer_done <= 1'b0;
      end else begin
         req_en      <= 1'b0;
         writer_done <= 1'b0;
         if (writer_start) begin
            busy   <= 1'b1;
            step   <= 2'd0;
            req_en <= 1'b1;
         end else if (busy && mem_rsp.enable) begin
            if (step == 2'd3) begin
               busy        <= 1'b0;
               writer_done <= 1'b1;
            end else begin
               step   <= step + 2'd1;
               req_en <= 1'b1;
            end
         end
      end
   end

endmodule

// File: src/virtio_blk_top.sv
`timescale 1ns/1ps

module virtio_blk_top (
   input  logic                      clk,
   input  logic                      rstn,
   input  virtio_blk_pkg::axil_req_t core_req,
   output virtio_blk_pkg::axil_rsp_t core_rsp,
   output virtio_blk_pkg::mem_req_t  mem_req,
   input  virtio_blk_pkg::mem_rsp_t  mem_rsp,
   output logic                      virtio_interrupt
);
   import virtio_blk_pkg::*;

   ring_cfg_t   ring_cfg;
   logic        notify;
   logic        irq_raise;
   logic        loader_start;
   logic        loader_done;
   logic        writer_start;
   logic        writer_done;
   logic [15:0] head_idx;
   logic [15:0] used_idx;
   mem_req_t    loader_req;
   mem_req_t    writer_req;
   chain_info_t chain;

   virtio_mmio_regs u_regs (
      .clk              (clk),
      .rstn             (rstn),
      .core_req         (core_req),
      .core_rsp         (core_rsp),
      .ring_cfg         (ring_cfg),
      .notify           (notify),
      .irq_raise        (irq_raise),
      .virtio_interrupt (virtio_interrupt)
   );

   virtq_ctrl u_ctrl (
      .clk          (clk),
      .rstn         (rstn),
      .notify       (notify),
      .ring_cfg     (ring_cfg),
      .mem_req      (mem_req),
      .mem_rsp      (mem_rsp),
      .loader_start (loader_start),
      .head_idx     (head_idx),
      .loader_req   (loader_req),
      .loader_done  (loader_done),
      .writer_start (writer_start),
      .used_idx     (used_idx),
      .writer_req   (writer_req),
      .writer_done  (writer_done),
      .irq_raise    (irq_raise)
   );

   // responses fan out, only the busy block listens
   desc_loader u_loader (
      .clk          (clk),
      .rstn         (rstn),
      .loader_start (loader_start),
      .head_idx     (head_idx),
      .ring_cfg     (ring_cfg),
      .loader_req   (loader_req),
      .mem_rsp      (mem_rsp),
      .loader_done  (loader_done),
      .chain        (chain)
   );

   completion_writer u_writer (
      .clk          (clk),
      .rstn         (rstn),
      .writer_start (writer_start),
      .chain        (chain),
      .used_idx     (used_idx),
      .ring_cfg     (ring_cfg),
      .writer_req   (writer_req),
      .mem_rsp      (mem_rsp),
      .writer_done  (writer_done)
   );

endmodule

// File: dv/virtio_mem_model.sv
`timescale 1ns/1ps

module virtio_mem_model #(
   parameter int WORDS   = 4096,
   parameter int LATENCY = 2
) (
   input  logic                     clk,
   input  logic                     rstn,
   input  virtio_blk_pkg::mem_req_t req,
   output virtio_blk_pkg::mem_rsp_t rsp
);
   import virtio_blk_pkg::*;

   logic [31:0] mem [WORDS];
   mem_req_t    held;
   logic        busy;
   int          count;
   logic [11:0] word_idx;

   assign word_idx = held.addr[13:2];

   // background pattern, every word differs
   initial begin
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = {16'hfeed ^ 16'(i), 16'(i)};
      end
   end

   always @(posedge clk) begin
      if (rstn) begin
         busy       <= 1'b0;
         count      <= 0;
         rsp.enable <= 1'b0;
         rsp.data   <= 32'h0;
      end else begin
         rsp.enable <= 1'b0;
         if (req.enable && !busy) begin
            held  <= req;
            busy  <= 1'b1;
            count <= LATENCY - 1;
         end else if (busy) begin
            if (count == 0) begin
               busy       <= 1'b0;
               rsp.enable <= 1'b1;
               rsp.data   <= mem[word_idx];
               if (held.mode == MEM_WRITE) begin
                  for (int b = 0; b < 4; b++) begin
                     if (held.wstrb[b]) begin
                        mem[word_idx][8*b +: 8] <= held.wdata[8*b +: 8];
                     end
                  end
               end
            end else begin
               count <= count - 1;
            end
         end
      end
   end

endmodule

// File: dv/virtio_blk_tb.sv
`timescale 1ns/1ps

module virtio_blk_tb;
   import virtio_blk_pkg::*;

   typedef struct packed {
      logic [15:0]      queue_num;
      logic [19:0]      pfn;
      logic [1:0]       n_req;
      logic [15:0]      start_used;
      logic [2:0][31:0] btypes;
   } row_t;

   localparam int NUM_ROWS    = 4;
   localparam int CYCLE_LIMIT = 3000 * NUM_ROWS;

   logic      clk;
   logic      rstn;
   axil_req_t core_req;
   axil_rsp_t core_rsp;
   mem_req_t  mem_req;
   mem_rsp_t  mem_rsp;
   logic      virtio_interrupt;

   row_t   rows [NUM_ROWS];
   integer seed;
   int     errors;
   int     tests_passed;
   int     tests_failed;
   int     cycles;
   int     irq_rises;
   logic   irq_prev;
   int     used_count;

   virtio_blk_top UUT (
      .clk              (clk),
      .rstn             (rstn),
      .core_req         (core_req),
      .core_rsp         (core_rsp),
      .mem_req          (mem_req),
      .mem_rsp          (mem_rsp),
      .virtio_interrupt (virtio_interrupt)
   );

   virtio_mem_model u_mem (
      .clk  (clk),
      .rstn (rstn),
      .req  (mem_req),
      .rsp  (mem_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // watchdog and interrupt edge counter
   always @(posedge clk) begin
      cycles   <= cycles + 1;
      irq_prev <= virtio_interrupt;
      if (virtio_interrupt && !irq_prev) begin
         irq_rises <= irq_rises + 1;
      end
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, the DUT stopped responding", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // helpers

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic finish_test(input string name, input int err_start);
      if (errors == err_start) begin
         tests_passed++;
         $display("test %s: pass", name);
      end else begin
         tests_failed++;
         $display("test %s: FAIL (%0d errors)", name, errors - err_start);
      end
   endtask

   task automatic bus_write(input logic [11:0] ofs, input logic [31:0] data, input int hold);
      @(posedge clk);
      core_req.awaddr  <= {20'h0, ofs};
      core_req.wdata   <= data;
      core_req.awvalid <= 1'b1;
      core_req.wvalid  <= 1'b1;
      forever begin
         @(posedge clk);
         if (core_req.awvalid && core_rsp.awready) core_req.awvalid <= 1'b0;
         if (core_req.wvalid && core_rsp.wready) core_req.wvalid <= 1'b0;
         if (core_rsp.bvalid) break;
      end
      check_value("bresp", {30'h0, core_rsp.bresp}, 32'h0);
      repeat (hold) begin
         @(posedge clk);
         check_value("bvalid", {31'h0, core_rsp.bvalid}, 32'h1);
      end
      core_req.bready <= 1'b1;
      @(posedge clk);
      core_req.bready <= 1'b0;
   endtask

   task automatic bus_read(input logic [11:0] ofs, input int hold, output logic [31:0] data);
      @(posedge clk);
      core_req.araddr  <= {20'h0, ofs};
      core_req.arvalid <= 1'b1;
      forever begin
         @(posedge clk);
         if (core_req.arvalid && core_rsp.arready) core_req.arvalid <= 1'b0;
         if (core_rsp.rvalid) break;
      end
      data = core_rsp.rdata;
      repeat (hold) begin
         @(posedge clk);
         check_value("rvalid", {31'h0, core_rsp.rvalid}, 32'h1);
         check_value("rdata held", core_rsp.rdata, data);
      end
      core_req.rready <= 1'b1;
      @(posedge clk);
      core_req.rready <= 1'b0;
   endtask

   task automatic read_expect(input string name, input logic [11:0] ofs,
                              input logic [31:0] exp, input int hold);
      logic [31:0] got;
      bus_read(ofs, hold, got);
      check_value(name, got, exp);
   endtask

   // used ring starts on the next 4 KiB page after the avail ring
   function automatic logic [31:0] used_ring_base(input int qn, input logic [19:0] pfn);
      logic [31:0] avail_end;
      avail_end = {pfn, 12'h000} + 32'(16 * qn) + 32'd4 + 32'(4 * qn);
      return (avail_end + 32'd4095) & 32'hffff_f000;
   endfunction

   function automatic logic [7:0] expected_status(input logic [31:0] btype);
      return (btype == 32'd0 || btype == 32'd1) ? 8'd0 : 8'd2;
   endfunction

   task automatic load_table();
      rows[0] = '{16'd8,  20'd1, 2'd1, 16'd0, {32'd0, 32'd0, 32'd0}};
      rows[1] = '{16'd16, 20'd0, 2'd2, 16'd1, {32'd0, 32'd1, 32'd7}};
      rows[2] = '{16'd16, 20'd2, 2'd3, 16'd3, {32'd5, 32'd0, 32'd1}};
      // wraps the used ring past slot 7
      rows[3] = '{16'd8,  20'd1, 2'd3, 16'd6, {32'd1, 32'd7, 32'd0}};
   endtask

   ////////////////////////////////////////////////////////////////////////
   // tests

   task automatic test_identity();
      int err_start;
      err_start = errors;
      read_expect("magic", 12'h000, 32'h7472_6976, 0);
      read_expect("version", 12'h004, 32'd1, 0);
      read_expect("device_id", 12'h008, 32'd2, 0);
      read_expect("vendor_id", 12'h00c, 32'h554d_4551, 0);
      read_expect("queue_num_max", 12'h034, 32'd8, 0);
      read_expect("unknown offset", 12'h0fc, 32'h0, 0);
      finish_test("identity registers", err_start);
   endtask

   task automatic test_config();
      int err_start;
      err_start = errors;
      bus_write(REG_QUEUE_NUM, 32'd5, 3);
      bus_write(REG_QUEUE_PFN, 32'h0001_2345, 0);
      bus_write(REG_STATUS, 32'h0000_000f, 2);
      read_expect("queue_num", REG_QUEUE_NUM, 32'd5, 2);
      read_expect("queue_pfn", REG_QUEUE_PFN, 32'h0001_2345, 0);
      read_expect("status", REG_STATUS, 32'h0000_000f, 4);
      finish_test("config registers", err_start);
   endtask

   task automatic run_row(input int r);
      row_t        row;
      int          qn;
      int          n;
      int          heads [3];
      int          cand;
      bit          ok;
      int          rises_before;
      int          err_start;
      int          slot;
      logic [31:0] bufs [16];
      logic [31:0] desc_base;
      logic [31:0] avail_base;
      logic [31:0] used_base;
      logic [31:0] status_addr;
      logic [31:0] entry;
      row = rows[r];
      qn = int'(row.queue_num);
      n = int'(row.n_req);
      err_start = errors;
      desc_base = {row.pfn, 12'h000};
      avail_base = desc_base + 32'(16 * qn);
      used_base = used_ring_base(qn, row.pfn);

      // descriptors chained in ring order over buffers near the top of memory
      for (int i = 0; i < qn; i++) begin
         bufs[i] = 32'h3800 + 32'(64 * i) + ((32'($random(seed)) & 32'hf) << 2);
         u_mem.mem[12'((desc_base + 32'(16 * i) + 32'd4) >> 2)] = bufs[i];
         u_mem.mem[12'((desc_base + 32'(16 * i) + 32'd12) >> 2)] =
            {16'h0001, 16'((i + 1) % qn)};
      end
      // heads must not land on another chain's status descriptor
      for (int k = 0; k < n; k++) begin
         do begin
            cand = int'($unsigned($random(seed)) % qn);
            ok = 1'b1;
            for (int j = 0; j < k; j++) begin
               if (cand == heads[j] || cand == (heads[j] + 2) % qn ||
                   heads[j] == (cand + 2) % qn) begin
                  ok = 1'b0;
               end
            end
         end while (!ok);
         heads[k] = cand;
         slot = (int'(row.start_used) + k) % qn;
         u_mem.mem[12'(bufs[cand] >> 2)] = row.btypes[k];
         u_mem.mem[12'(bufs[(cand + 2) % qn] >> 2)] = 32'h5a5a_5aee;
         u_mem.mem[12'((avail_base + 32'd4 + 32'(4 * slot)) >> 2)] = 32'(cand);
         u_mem.mem[12'((used_base + 32'd4 + 32'(8 * slot)) >> 2)] = 32'hffff_ffff;
         u_mem.mem[12'((used_base + 32'd8 + 32'(8 * slot)) >> 2)] = 32'hffff_ffff;
      end
      u_mem.mem[12'(avail_base >> 2)] = 32'(int'(row.start_used) + n);
      u_mem.mem[12'(used_base >> 2)] = 32'hffff_ffff;

      bus_write(REG_QUEUE_NUM, {16'h0, row.queue_num}, 0);
      bus_write(REG_QUEUE_PFN, {12'h0, row.pfn}, 0);
      rises_before = irq_rises;
      bus_write(REG_QUEUE_NOTIFY, 32'h0, 0);
      while (!virtio_interrupt) @(posedge clk);

      for (int k = 0; k < n; k++) begin
         slot = (int'(row.start_used) + k) % qn;
         status_addr = bufs[(heads[k] + 2) % qn];
         check_value("status byte", u_mem.mem[12'(status_addr >> 2)],
                     {24'h5a5a5a, expected_status(row.btypes[k])});
         entry = used_base + 32'd4 + 32'(8 * slot);
         check_value("used id", u_mem.mem[12'(entry >> 2)], 32'(heads[k]));
         check_value("used len", u_mem.mem[12'((entry + 32'd4) >> 2)], 32'h0);
      end
      used_count = used_count + n;
      check_value("used idx", u_mem.mem[12'(used_base >> 2)], 32'(used_count));
      read_expect("int_status", REG_INT_STATUS, 32'h1, 1);

      bus_write(REG_INT_ACK, 32'h1, 0);
      @(posedge clk);
      check_value("virtio_interrupt", {31'h0, virtio_interrupt}, 32'h0);
      read_expect("int_status after ack", REG_INT_STATUS, 32'h0, 0);
      repeat (20) @(posedge clk);
      check_value("interrupt rises", 32'(irq_rises - rises_before), 32'h1);
      finish_test($sformatf("row %0d", r), err_start);
   endtask

   ////////////////////////////////////////////////////////////////////////
   initial begin
      seed = 33;
      errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      cycles = 0;
      irq_rises = 0;
      irq_prev = 1'b0;
      used_count = 0;
      core_req = '0;
      rstn = 1'b1;
      load_table();
      repeat (8) @(posedge clk);
      rstn <= 1'b0;
      repeat (2) @(posedge clk);

      test_identity();
      test_config();
      for (int r = 0; r < NUM_ROWS; r++) begin
         run_row(r);
      end

      $display("tests passed %0d, failed %0d, failing checks %0d",
               tests_passed, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: virtio_blk.f
src/virtio_blk_pkg.sv
src/virtio_mmio_regs.sv
src/virtq_ctrl.sv
src/desc_loader.sv
src/completion_writer.sv
src/virtio_blk_top.sv
dv/virtio_mem_model.sv
dv/virtio_blk_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module virtio_blk_tb -f virtio_blk.f \
   --Mdir obj_dir -o virtio_blk_sim > build.log 2>&1 \
   && ./obj_dir/virtio_blk_sim > sim.log 2>&1 \
   ; grep -q "Simulation completed successfully" sim.log \
   && echo "PASS" \
   || { echo "FAIL, see build.log and sim.log"; exit 1; }
